/* Bender.yml */
package:
  name: soc_core

sources:
  - files:
      - logic/soc_pkg.sv
      - logic/wb_bus_if.sv
      - logic/wb_switch.sv
      - logic/gpio_port.sv
      - logic/pit_timer.sv
      - logic/int_ctrl.sv
      - logic/soc_core.sv
  - target: test
    files:
      - verif/clk_gen.sv
      - verif/soc_tb.sv

/* files.f */
logic/soc_pkg.sv
logic/wb_bus_if.sv
logic/wb_switch.sv
logic/gpio_port.sv
logic/pit_timer.sv
logic/int_ctrl.sv
logic/soc_core.sv
verif/clk_gen.sv
verif/soc_tb.sv

/* logic/gpio_port.sv */
// LEDs at word 0, switches at word 1; ack comes one clock late and writes land on it
`timescale 1ns/1ns

module gpio_port (
  input  logic           clk,
  input  logic           rst_lck,
  wb_bus_if.slave        bus,
  input  soc_pkg::led_t  sw_i,
  output soc_pkg::led_t  leds_o
);
  import soc_pkg::*;

  led_t leds_q;
  logic ack_q;
  logic wr_leds;

  // Write completes at the edge where ack is seen
  assign wr_leds = ack_q & bus.cyc & bus.stb & bus.we & ~bus.adr[0];

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      ack_q  <= 1'b0;
      leds_q <= '0;
    end else begin
      ack_q <= bus.cyc & bus.stb & ~ack_q;   // One cycle pulse
      if (wr_leds && bus.sel[0]) begin
        leds_q[7:0] <= bus.dat_w[7:0];
      end
      if (wr_leds && bus.sel[1]) begin
        leds_q[9:8] <= bus.dat_w[9:8];       // High byte only carries two LEDs
      end
    end
  end

  // Upper read bits are zero
  assign bus.dat_r = bus.adr[0] ? data_t'(sw_i) : data_t'(leds_q);
  assign bus.ack   = ack_q;
  assign leds_o    = leds_q;

  // The write lands on the ack edge, so the request must still be there
  assert property (@(posedge clk) disable iff (!rst_lck)
    bus.cyc && bus.stb && !bus.ack |=>
      bus.cyc && bus.stb && $stable(bus.adr) && $stable(bus.we))
    else $error("GPIO request dropped or changed before its ack");

endmodule

/* logic/int_ctrl.sv */
// Rising edges only, lowest line wins; inta_i is a single cycle pulse given only while intr_o is high
`timescale 1ns/1ns

module int_ctrl (
  input  logic              clk,
  input  logic              rst_lck,
  input  soc_pkg::irq_vec_t irq_i,
  input  logic              inta_i,
  input  soc_pkg::data_t    bus_dat_i,
  output soc_pkg::data_t    m_dat_o,
  output logic              intr_o
);
  import soc_pkg::*;

  irq_vec_t irq_s_q;    // Sampled request lines
  irq_vec_t irq_d_q;    // One clock older, for the edge
  irq_vec_t pend_q;
  irq_vec_t rise;
  irq_vec_t clr;
  irq_id_t  irq_id;

  assign rise = irq_s_q & ~irq_d_q;

  // Priority encoder, line 0 highest
  always_comb begin
    irq_id = '0;
    for (int i = $bits(irq_vec_t) - 1; i >= 0; i--) begin
      if (pend_q[i]) begin
        irq_id = irq_id_t'(i);
      end
    end
  end

  assign clr = inta_i ? (irq_vec_t'(1) << irq_id) : '0;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      irq_s_q <= '0;
      irq_d_q <= '0;
      pend_q  <= '0;
    end else begin
      irq_s_q <= irq_i;
      irq_d_q <= irq_s_q;
      pend_q  <= (pend_q & ~clr) | rise;   // New edge beats the clear
    end
  end

  assign intr_o = |pend_q;

  // Vector goes out in place of the bus read data
  assign m_dat_o = inta_i ? IRQ_VECTOR_BASE + data_t'(irq_id) : bus_dat_i;

  // An acknowledge with nothing pending would hand out a bogus vector
  assert property (@(posedge clk) disable iff (!rst_lck)
    inta_i |-> intr_o)
    else $error("inta_i without a pending interrupt");

endmodule

/* logic/pit_timer.sv */
// Fixed period only; the first tick is TIMER_PERIOD clocks after reset release, then one every TIMER_PERIOD clocks
`timescale 1ns/1ns

module pit_timer (
  input  logic clk,
  input  logic rst_lck,
  output logic tick_o
);
  import soc_pkg::*;

  logic [$clog2(TIMER_PERIOD)-1:0] cnt_q;
  logic                            tick_q;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt_q  <= '0;
      tick_q <= 1'b0;
    end else begin
      tick_q <= cnt_q == TIMER_PERIOD - 1;   // Registered wrap flag
      if (cnt_q == TIMER_PERIOD - 1) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign tick_o = tick_q;

endmodule

/* logic/soc_core.sv */
// Bus master and interrupt acknowledge come from outside; one clock, synchronous active low reset
`timescale 1ns/1ns

module soc_core (
  input  logic            clk,
  input  logic            rst_lck,

  // External bus master
  input  soc_pkg::addr_t  m_adr_i,
  input  soc_pkg::data_t  m_dat_i,
  input  soc_pkg::sel_t   m_sel_i,
  input  logic            m_we_i,
  input  logic            m_cyc_i,
  input  logic            m_stb_i,
  output soc_pkg::data_t  m_dat_o,
  output logic            m_ack_o,

  // Interrupts
  input  logic [6:0]      irq_i,     // Lines 1 to 7
  output logic            intr_o,
  input  logic            inta_i,

  // Board I/O
  input  soc_pkg::led_t   sw_i,
  output soc_pkg::led_t   leds_o
);
  import soc_pkg::*;

  wb_bus_if gpio_bus ();

  data_t    sw_dat;     // Read data out of the switch
  irq_vec_t irq_req;
  logic     tick;

  // Timer on its own line, outside requests above it
  assign irq_req = {irq_i, 1'b0} | (irq_vec_t'(tick) << TIMER_IRQ);

  wb_switch wbs (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .m_adr_i   (m_adr_i),
    .m_dat_i   (m_dat_i),
    .m_sel_i   (m_sel_i),
    .m_we_i    (m_we_i),
    .m_cyc_i   (m_cyc_i),
    .m_stb_i   (m_stb_i),
    .bus_dat_o (sw_dat),
    .m_ack_o   (m_ack_o),
    .gpio      (gpio_bus)
  );

  gpio_port gpio (
    .clk     (clk),
    .rst_lck (rst_lck),
    .bus     (gpio_bus),
    .sw_i    (sw_i),
    .leds_o  (leds_o)
  );

  pit_timer timer0 (
    .clk     (clk),
    .rst_lck (rst_lck),
    .tick_o  (tick)
  );

  int_ctrl pic0 (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .irq_i     (irq_req),
    .inta_i    (inta_i),
    .bus_dat_i (sw_dat),
    .m_dat_o   (m_dat_o),
    .intr_o    (intr_o)
  );

endmodule

/* logic/soc_pkg.sv */
// Single clock domain; bus addresses are word addresses with the I/O flag in bit 19, timer period cut down for simulation
package soc_pkg;

  // Bus fields
  typedef logic [15:0] data_t;      // One bus data word
  typedef logic [19:0] addr_t;      // {io flag, address bits 19:1}
  typedef logic [1:0]  sel_t;       // Byte lanes, bit 0 is the low byte

  // Interrupt side
  typedef logic [7:0]  irq_vec_t;   // One bit per request line
  typedef logic [2:0]  irq_id_t;    // Interrupt number

  // Board I/O
  typedef logic [9:0]  led_t;       // LEDs and switches

  // GPIO window, io 0xf100 - 0xf103
  // Compare against the base on every bit set in the mask
  localparam addr_t GPIO_BASE = 20'b1_0000_1111_0001_0000_000;
  localparam addr_t GPIO_MASK = 20'b1_0000_1111_1111_1111_110;

  // Data returned for any address outside the windows
  localparam data_t DEFAULT_READ = 16'hffff;

  // Periodic timer, clocks per tick
  localparam int TIMER_PERIOD = 200;

  // Interrupt line of the timer
  localparam irq_id_t TIMER_IRQ = 3'd0;

  // Vector = base + interrupt number
  localparam data_t IRQ_VECTOR_BASE = 16'd8;

endpackage

/* logic/wb_bus_if.sv */
// One slave port of the switch; the master holds every request signal until it sees ack
`timescale 1ns/1ns

interface wb_bus_if;
  import soc_pkg::*;

  data_t dat_w;   // Write data from the master
  data_t dat_r;   // Read data from the slave
  addr_t adr;
  sel_t  sel;
  logic  we;
  logic  cyc;
  logic  stb;
  logic  ack;

  modport master (
    output dat_w, adr, sel, we, cyc, stb,
    input  dat_r, ack
  );

  modport slave (
    input  dat_w, adr, sel, we, cyc, stb,
    output dat_r, ack
  );

endinterface

/* logic/wb_switch.sv */
// Purely combinational decode with one GPIO window; every miss is answered at once with all ones and writes are dropped
`timescale 1ns/1ns

module wb_switch (
  input  logic            clk,       // Only for the check below
  input  logic            rst_lck,

  // Master side
  input  soc_pkg::addr_t  m_adr_i,
  input  soc_pkg::data_t  m_dat_i,
  input  soc_pkg::sel_t   m_sel_i,
  input  logic            m_we_i,
  input  logic            m_cyc_i,
  input  logic            m_stb_i,
  output soc_pkg::data_t  bus_dat_o,
  output logic            m_ack_o,

  // GPIO slave port
  wb_bus_if.master        gpio
);
  import soc_pkg::*;

  logic gpio_hit;
  logic def_ack;

  // Window match on the masked bits, I/O flag included
  assign gpio_hit = (m_adr_i & GPIO_MASK) == GPIO_BASE;

  // Request fields go out unchanged
  assign gpio.adr   = m_adr_i;
  assign gpio.dat_w = m_dat_i;
  assign gpio.sel   = m_sel_i;
  assign gpio.we    = m_we_i;

  // Only the selected slave sees the strobes
  assign gpio.cyc = m_cyc_i & gpio_hit;
  assign gpio.stb = m_stb_i & gpio_hit;

  // Default responder, acks in the same cycle
  assign def_ack = m_cyc_i & m_stb_i & ~gpio_hit;

  always_comb begin
    if (gpio_hit) begin
      bus_dat_o = gpio.dat_r;
      m_ack_o   = gpio.ack;
    end else begin
      bus_dat_o = DEFAULT_READ;    // Reads all ones
      m_ack_o   = def_ack;
    end
  end

  // The slave answer must stay inside the master's request
  assert property (@(posedge clk) disable iff (!rst_lck)
    m_ack_o |-> (m_cyc_i && m_stb_i))
    else $error("ack outside of a bus request");

endmodule

/* verif/clk_gen.sv */
// Free running clock with a 4 ns period; reset is held low for 5 cycles and released on a falling edge
`timescale 1ns/1ns

module clk_gen (
  output logic clk,
  output logic rst_lck
);
  localparam int HALF_PERIOD  = 2;
  localparam int RESET_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst_lck = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_lck = 1'b1;                 // Release away from the sampling edge
  end

endmodule

/* verif/soc_tb.sv */
// Stops at the first error; timer ticks are predicted by counting clocks from reset release
`timescale 1ns/1ns

module soc_tb;
  import soc_pkg::*;

  localparam int unsigned SEED = 32'h975a;
  localparam int CLK_PERIOD_NS = 4;
  localparam int N_GPIO        = 40;    // LED write and read pairs
  localparam int N_SW          = 20;
  localparam int N_DEF         = 30;
  localparam int N_IRQ         = 20;
  localparam int TIMER_ROUNDS  = 5;
  localparam int ACK_LIMIT     = 8;     // Longest bus access in cycles
  localparam int TICK_MARGIN   = 3;     // Tick until its pending bit shows on intr_o
  localparam int CYCLE_BOUND   = 16;
  localparam int N_TRANS       = 2 * (N_GPIO + N_SW + N_DEF) + 8 * N_IRQ;
  localparam int WATCHDOG_NS   = (N_TRANS * CYCLE_BOUND + 20 * TIMER_PERIOD) * CLK_PERIOD_NS;

  logic       clk;
  logic       rst_lck;
  addr_t      m_adr_i;
  data_t      m_dat_i;
  sel_t       m_sel_i;
  logic       m_we_i;
  logic       m_cyc_i;
  logic       m_stb_i;
  data_t      m_dat_o;
  logic       m_ack_o;
  logic [6:0] irq_i;
  logic       intr_o;
  logic       inta_i;
  led_t       sw_i;
  led_t       leds_o;

  led_t       leds_m;                   // Model of the LED register
  irq_vec_t   pend_m;                   // Model of the pending bits
  int         ticks_seen;
  int         cyc_cnt;                  // Rising edges since reset release

  clk_gen clocks (.clk(clk), .rst_lck(rst_lck));

  soc_core UUT (.*);

  always @(posedge clk) begin
    if (!rst_lck) begin
      cyc_cnt <= 0;
    end else begin
      cyc_cnt <= cyc_cnt + 1;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic logic in_gpio_window(input addr_t a);
    return (a & GPIO_MASK) == (GPIO_BASE & GPIO_MASK);
  endfunction

  // Random don't care bits, word select in bit 0
  function automatic addr_t gpio_addr(input logic word);
    addr_t a;
    a    = (addr_t'($urandom) & ~GPIO_MASK) | GPIO_BASE;
    a[0] = word;
    return a;
  endfunction

  function automatic addr_t miss_addr(input logic io);
    addr_t a;
    do begin
      if ($urandom_range(1) == 0) begin
        a = GPIO_BASE ^ (addr_t'(1) << $urandom_range(18, 1));   // Just beside the window
      end else begin
        a = addr_t'($urandom);
      end
      a[19] = io;
    end while (in_gpio_window(a));
    return a;
  endfunction

  function automatic int lowest_pending(input irq_vec_t p);
    for (int i = 0; i < $bits(irq_vec_t); i++) begin
      if (p[i]) begin
        return i;
      end
    end
    return -1;
  endfunction

  // Starts and ends on a falling edge; ack and data are sampled 1 ns after the drive
  task automatic bus_access(input addr_t adr, input logic we, input sel_t sel, input data_t wdat,
                            output data_t rdat, output int cycles);
    m_adr_i = adr;
    m_dat_i = wdat;
    m_sel_i = sel;
    m_we_i  = we;
    m_cyc_i = 1'b1;
    m_stb_i = 1'b1;
    cycles  = 1;
    #1;
    while (!m_ack_o && cycles < ACK_LIMIT) begin
      @(negedge clk);
      cycles++;
      #1;
    end
    if (!m_ack_o) begin
      abort_run($sformatf("Bus access to address 0x%h got no ack", adr));
    end
    rdat = m_dat_o;
    @(negedge clk);                     // Transfer completes at the edge in between
    m_cyc_i = 1'b0;
    m_stb_i = 1'b0;
    m_we_i  = 1'b0;
  endtask

  task automatic int_ack(output data_t vec);
    inta_i = 1'b1;
    #1;
    vec = m_dat_o;
    @(negedge clk);
    inta_i = 1'b0;
  endtask

  // Wait out the cycles right after a tick, then add any passed tick to the model
  task automatic settle_timer();
    int ticks;
    while (cyc_cnt >= TIMER_PERIOD && cyc_cnt % TIMER_PERIOD < TICK_MARGIN) @(negedge clk);
    ticks = cyc_cnt / TIMER_PERIOD;
    if (ticks > ticks_seen) begin
      pend_m[TIMER_IRQ] = 1'b1;
      ticks_seen        = ticks;
    end
  endtask

  task automatic drain_interrupts();
    int    lowest;
    data_t vec;
    settle_timer();
    check_equal("intr_o", intr_o, |pend_m);
    while (pend_m != '0) begin
      lowest = lowest_pending(pend_m);
      int_ack(vec);
      check_equal("m_dat_o", vec, IRQ_VECTOR_BASE + data_t'(lowest));
      pend_m[lowest] = 1'b0;
      settle_timer();
      check_equal("intr_o", intr_o, |pend_m);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    abort_run("Watchdog timeout, the tests did not finish in time");
  end

  initial begin
    data_t      rdat;
    data_t      wdat;
    sel_t       sel;
    addr_t      adr;
    int         cycles;
    logic [6:0] pulse;
    m_adr_i    = '0;
    m_dat_i    = '0;
    m_sel_i    = '0;
    m_we_i     = 1'b0;
    m_cyc_i    = 1'b0;
    m_stb_i    = 1'b0;
    irq_i      = '0;
    inta_i     = 1'b0;
    sw_i       = '0;
    leds_m     = '0;
    pend_m     = '0;
    ticks_seen = 0;
    void'($urandom(SEED));
    @(posedge rst_lck);
    check_equal("leds_o", leds_o, 0);
    check_equal("intr_o", intr_o, 0);
    check_equal("m_ack_o", m_ack_o, 0);

    for (int i = 0; i < N_GPIO; i++) begin
      sel  = sel_t'($urandom);
      wdat = data_t'($urandom);
      bus_access(gpio_addr(1'b0), 1'b1, sel, wdat, rdat, cycles);
      if (sel[0]) begin
        leds_m[7:0] = wdat[7:0];
      end
      if (sel[1]) begin
        leds_m[9:8] = wdat[9:8];        // Rest of the high byte is not stored
      end
      check_equal("m_ack_o cycles", cycles, 2);
      check_equal("leds_o", leds_o, leds_m);
      bus_access(gpio_addr(1'b0), 1'b0, sel_t'($urandom), data_t'($urandom), rdat, cycles);
      check_equal("m_dat_o", rdat, {6'b0, leds_m});
    end

    for (int i = 0; i < N_SW; i++) begin
      sw_i = led_t'($urandom);
      bus_access(gpio_addr(1'b1), 1'b0, 2'b11, '0, rdat, cycles);
      check_equal("m_dat_o", rdat, {6'b0, sw_i});
      bus_access(gpio_addr(1'b1), 1'b1, sel_t'($urandom), data_t'($urandom), rdat, cycles);
      check_equal("leds_o", leds_o, leds_m);
    end

    for (int i = 0; i < N_DEF; i++) begin
      adr = miss_addr((i % 2) == 1);    // Memory and I/O space in turn
      bus_access(adr, 1'b0, sel_t'($urandom), data_t'($urandom), rdat, cycles);
      check_equal("m_ack_o cycles", cycles, 1);
      check_equal("m_dat_o", rdat, DEFAULT_READ);
      bus_access(adr, 1'b1, sel_t'($urandom), data_t'($urandom), rdat, cycles);
      check_equal("leds_o", leds_o, leds_m);
    end

    for (int i = 0; i < N_IRQ; i++) begin
      pulse  = 7'($urandom_range(127, 1));
      irq_i  = pulse;
      pend_m = pend_m | {pulse, 1'b0};
      @(negedge clk);
      irq_i = '0;
      repeat (TICK_MARGIN) @(negedge clk);
      drain_interrupts();
    end

    repeat (TIMER_ROUNDS) begin
      while (!pend_m[TIMER_IRQ]) begin
        @(negedge clk);
        settle_timer();
        check_equal("intr_o", intr_o, |pend_m);
      end
      drain_interrupts();
    end

    $display("Everything OK");
    $finish;
  end

endmodule
